/* design/dma_pkg.sv */
`default_nettype none

package dma_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;

   localparam addr_t reg_dma_addr   = 16'hFF46; // oam dma source page
   localparam addr_t reg_hdma1_addr = 16'hFF51; // source high
   localparam addr_t reg_hdma2_addr = 16'hFF52; // source low
   localparam addr_t reg_hdma3_addr = 16'hFF53; // destination high
   localparam addr_t reg_hdma4_addr = 16'hFF54; // destination low
   localparam addr_t reg_hdma5_addr = 16'hFF55; // mode / length / status

   localparam int    default_oam_len  = 160;    // bytes per oam transfer
   localparam byte_t default_oam_page = 8'hFE;  // sprite attribute page

   localparam logic [2:0] vram_base_bits = 3'b100; // every vram dest is 0x8000-0x9FFF
   localparam int         block_bytes    = 16;

   typedef struct packed {
      logic       hdma_mode;  // 1 = hblank dma, not supported
      logic [6:0] blocks_m1;  // block count minus one
   } hdma5_spec_t;

   typedef struct packed {
      logic       busy;
      logic [6:0] remain_m1;  // remaining whole blocks minus one
   } hdma5_status_t;

   // the same byte means a request when written and progress when read
   typedef union packed {
      hdma5_spec_t   spec;
      hdma5_status_t status;
   } hdma5_word_t;

endpackage

`default_nettype wire

/* design/dma_io_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_io_regs (
   input  wire                       I_CLK,
   input  wire                       I_SYNC_RESET,
   input  wire dma_pkg::addr_t       ioreg_addr,
   input  wire dma_pkg::byte_t       ioreg_wdata,
   input  wire                       ioreg_we_l,
   input  wire                       ioreg_re_l,
   output dma_pkg::byte_t            ioreg_rdata,
   input  wire dma_pkg::hdma5_word_t gdma_status,
   output logic                      oam_start,
   output dma_pkg::byte_t            oam_src_page,
   output logic                      gdma_start,
   output dma_pkg::addr_t            gdma_src,
   output dma_pkg::addr_t            gdma_dst,
   output logic [6:0]                gdma_blocks
);
   import dma_pkg::*;

   byte_t       dma_reg;
   byte_t       hdma1_reg;
   byte_t       hdma2_reg;
   byte_t       hdma3_reg;
   byte_t       hdma4_reg;
   hdma5_word_t hdma5_reg;    // last request written
   hdma5_word_t hdma5_wr;     // incoming byte seen as a request

   assign hdma5_wr = ioreg_wdata;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         dma_reg    <= '0;
         hdma1_reg  <= '0;
         hdma2_reg  <= '0;
         hdma3_reg  <= '0;
         hdma4_reg  <= '0;
         hdma5_reg  <= '0;
         oam_start  <= 1'b0;
         gdma_start <= 1'b0;
      end else begin
         oam_start  <= 1'b0; // single-cycle pulses
         gdma_start <= 1'b0;
         if (!ioreg_we_l) begin
            case (ioreg_addr)
               reg_dma_addr: begin
                  dma_reg   <= ioreg_wdata;
                  oam_start <= 1'b1;
               end
               reg_hdma1_addr: hdma1_reg <= ioreg_wdata;
               reg_hdma2_addr: hdma2_reg <= ioreg_wdata;
               reg_hdma3_addr: hdma3_reg <= ioreg_wdata;
               reg_hdma4_addr: hdma4_reg <= ioreg_wdata;
               reg_hdma5_addr: begin
                  hdma5_reg  <= hdma5_wr;
                  gdma_start <= ~hdma5_wr.spec.hdma_mode; // hblank requests dropped
               end
               default: ;
            endcase
         end
      end
   end

   assign oam_src_page = dma_reg;
   assign gdma_src     = {hdma1_reg, hdma2_reg[7:4], 4'h0};                  // 16-byte aligned
   assign gdma_dst     = {vram_base_bits, hdma3_reg[4:0], hdma4_reg[7:4], 4'h0};
   assign gdma_blocks  = hdma5_reg.spec.blocks_m1;

   always_comb begin
      ioreg_rdata = 8'h00;
      if (!ioreg_re_l) begin
         case (ioreg_addr)
            reg_dma_addr:   ioreg_rdata = dma_reg;
            reg_hdma1_addr: ioreg_rdata = hdma1_reg;
            reg_hdma2_addr: ioreg_rdata = hdma2_reg;
            reg_hdma3_addr: ioreg_rdata = hdma3_reg;
            reg_hdma4_addr: ioreg_rdata = hdma4_reg;
            reg_hdma5_addr: ioreg_rdata = {gdma_status.status.busy,
                                           gdma_status.status.remain_m1};
            default:        ioreg_rdata = 8'h00; // not ours
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/oam_dma_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module oam_dma_engine #(
   parameter int             OAM_LEN  = dma_pkg::default_oam_len,
   parameter dma_pkg::byte_t OAM_PAGE = dma_pkg::default_oam_page
) (
   input  wire                 I_CLK,
   input  wire                 I_SYNC_RESET,
   input  wire                 oam_start,
   input  wire dma_pkg::byte_t oam_src_page,
   output logic                active,
   output dma_pkg::addr_t      rd_addr,
   output dma_pkg::addr_t      wr_addr
);
   import dma_pkg::*;

   localparam logic st_idle = 1'b0;
   localparam logic st_xfer = 1'b1;

   logic  state;
   byte_t count;     // byte offset within the page
   byte_t src_page;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state <= st_idle;
         count <= '0;
      end else if (state == st_idle) begin
         if (oam_start) begin
            state <= st_xfer;
            count <= '0;
         end
      end else if (count == 8'(OAM_LEN - 1)) begin
         state <= st_idle; // last byte moved this cycle
         count <= '0;
      end else begin
         count <= count + 8'd1;
      end
   end

   always_ff @(posedge I_CLK) begin
      if (state == st_idle && oam_start)
         src_page <= oam_src_page; // held for the whole copy
   end

   assign active  = (state == st_xfer);
   assign rd_addr = {src_page, 8'h00} + {8'h00, count};
   assign wr_addr = {OAM_PAGE, 8'h00} + {8'h00, count};

endmodule

`default_nettype wire

/* design/gdma_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module gdma_engine (
   input  wire                 I_CLK,
   input  wire                 I_SYNC_RESET,
   input  wire                 gdma_start,
   input  wire dma_pkg::addr_t gdma_src,
   input  wire dma_pkg::addr_t gdma_dst,
   input  wire [6:0]           gdma_blocks,
   output logic                active,
   output dma_pkg::addr_t      rd_addr,
   output dma_pkg::addr_t      wr_addr,
   output dma_pkg::hdma5_word_t gdma_status
);
   import dma_pkg::*;

   localparam logic st_idle = 1'b0;
   localparam logic st_xfer = 1'b1;

   logic        state;
   logic [15:0] count;
   logic [15:0] len_q;        // 16 * (blocks + 1)
   addr_t       src_q;
   addr_t       dst_q;
   logic [15:0] bytes_left;   // minus one, so a full block reads as its own index
   logic [15:0] blocks_left;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state <= st_idle;
         count <= '0;
      end else if (state == st_idle) begin
         if (gdma_start) begin
            state <= st_xfer;
            count <= '0;
         end
      end else if (count == len_q - 16'd1) begin
         state <= st_idle;
         count <= '0;
      end else begin
         count <= count + 16'd1;
      end
   end

   always_ff @(posedge I_CLK) begin
      if (state == st_idle && gdma_start) begin
         src_q <= gdma_src;
         dst_q <= gdma_dst;
         len_q <= ({9'd0, gdma_blocks} + 16'd1) * 16'(block_bytes);
      end
   end

   assign active      = (state == st_xfer);
   assign rd_addr     = src_q + count;
   assign wr_addr     = dst_q + count;
   assign bytes_left  = len_q - count - 16'd1;
   assign blocks_left = bytes_left / 16'(block_bytes);

   always_comb begin
      gdma_status = '0; // idle reads 0x00
      if (state == st_xfer) begin
         gdma_status.status.busy      = 1'b1;
         gdma_status.status.remain_m1 = blocks_left[6:0];
      end
   end

endmodule

`default_nettype wire

/* design/dma_bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_bus_arbiter (
   input  wire                 oam_active,
   input  wire dma_pkg::addr_t oam_rd_addr,
   input  wire dma_pkg::addr_t oam_wr_addr,
   input  wire                 gdma_active,
   input  wire dma_pkg::addr_t gdma_rd_addr,
   input  wire dma_pkg::addr_t gdma_wr_addr,
   input  wire dma_pkg::byte_t rdma_data,
   output dma_pkg::addr_t      rdma_addr,
   output logic                rdma_re_l,
   output dma_pkg::addr_t      wdma_addr,
   output dma_pkg::byte_t      wdma_data,
   output logic                wdma_we_l,
   output logic                halt_cpu
);

   logic any_active;

   assign any_active = oam_active | gdma_active;

   // oam wins when both run
   always_comb begin
      if (oam_active) begin
         rdma_addr = oam_rd_addr;
         wdma_addr = oam_wr_addr;
      end else if (gdma_active) begin
         rdma_addr = gdma_rd_addr;
         wdma_addr = gdma_wr_addr;
      end else begin
         rdma_addr = 16'h0000;
         wdma_addr = 16'h0000;
      end
   end

   assign rdma_re_l = ~any_active; // read and write strobe together
   assign wdma_we_l = ~any_active;
   assign wdma_data = rdma_data;   // zero-latency memory
   assign halt_cpu  = gdma_active;

endmodule

`default_nettype wire

/* design/dma_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_controller #(
   parameter int             OAM_LEN  = dma_pkg::default_oam_len,
   parameter dma_pkg::byte_t OAM_PAGE = dma_pkg::default_oam_page
) (
   input  wire                 I_CLK,
   input  wire                 I_SYNC_RESET,
   input  wire dma_pkg::addr_t ioreg_addr,
   input  wire dma_pkg::byte_t ioreg_wdata,
   input  wire                 ioreg_we_l,
   input  wire                 ioreg_re_l,
   output dma_pkg::byte_t      ioreg_rdata,
   output dma_pkg::addr_t      rdma_addr,
   output logic                rdma_re_l,
   input  wire dma_pkg::byte_t rdma_data,
   output dma_pkg::addr_t      wdma_addr,
   output dma_pkg::byte_t      wdma_data,
   output logic                wdma_we_l,
   output logic                halt_cpu
);
   import dma_pkg::*;

   logic        oam_start;
   byte_t       oam_src_page;
   logic        oam_active;
   addr_t       oam_rd_addr;
   addr_t       oam_wr_addr;
   logic        gdma_start;
   addr_t       gdma_src;
   addr_t       gdma_dst;
   logic [6:0]  gdma_blocks;
   logic        gdma_active;
   addr_t       gdma_rd_addr;
   addr_t       gdma_wr_addr;
   hdma5_word_t gdma_status;

   dma_io_regs dma_io_regs_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .ioreg_addr   (ioreg_addr),
      .ioreg_wdata  (ioreg_wdata),
      .ioreg_we_l   (ioreg_we_l),
      .ioreg_re_l   (ioreg_re_l),
      .ioreg_rdata  (ioreg_rdata),
      .gdma_status  (gdma_status),
      .oam_start    (oam_start),
      .oam_src_page (oam_src_page),
      .gdma_start   (gdma_start),
      .gdma_src     (gdma_src),
      .gdma_dst     (gdma_dst),
      .gdma_blocks  (gdma_blocks)
   );

   oam_dma_engine #(
      .OAM_LEN  (OAM_LEN),
      .OAM_PAGE (OAM_PAGE)
   ) oam_dma_engine_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .oam_start    (oam_start),
      .oam_src_page (oam_src_page),
      .active       (oam_active),
      .rd_addr      (oam_rd_addr),
      .wr_addr      (oam_wr_addr)
   );

   gdma_engine gdma_engine_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .gdma_start   (gdma_start),
      .gdma_src     (gdma_src),
      .gdma_dst     (gdma_dst),
      .gdma_blocks  (gdma_blocks),
      .active       (gdma_active),
      .rd_addr      (gdma_rd_addr),
      .wr_addr      (gdma_wr_addr),
      .gdma_status  (gdma_status)
   );

   dma_bus_arbiter dma_bus_arbiter_inst (
      .oam_active   (oam_active),
      .oam_rd_addr  (oam_rd_addr),
      .oam_wr_addr  (oam_wr_addr),
      .gdma_active  (gdma_active),
      .gdma_rd_addr (gdma_rd_addr),
      .gdma_wr_addr (gdma_wr_addr),
      .rdma_data    (rdma_data),
      .rdma_addr    (rdma_addr),
      .rdma_re_l    (rdma_re_l),
      .wdma_addr    (wdma_addr),
      .wdma_data    (wdma_data),
      .wdma_we_l    (wdma_we_l),
      .halt_cpu     (halt_cpu)
   );

endmodule

`default_nettype wire

/* sim/dma_controller_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_controller_assertions (
   input wire                 I_CLK,
   input wire                 I_SYNC_RESET,
   input wire                 rdma_re_l,
   input wire                 wdma_we_l,
   input wire                 halt_cpu,
   input wire dma_pkg::byte_t rdma_data,
   input wire dma_pkg::byte_t wdma_data
);

   enables_together: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      rdma_re_l == wdma_we_l)
      else $error("read enable and write enable disagree");

   data_passthrough: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      wdma_data == rdma_data)
      else $error("write data differs from read data");

   // cpu is only halted while some transfer is running
   halt_means_busy: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      halt_cpu |-> !rdma_re_l)
      else $error("cpu halted with no memory read in progress");

endmodule

bind dma_controller dma_controller_assertions dma_controller_assertions_inst (
   .I_CLK        (I_CLK),
   .I_SYNC_RESET (I_SYNC_RESET),
   .rdma_re_l    (rdma_re_l),
   .wdma_we_l    (wdma_we_l),
   .halt_cpu     (halt_cpu),
   .rdma_data    (rdma_data),
   .wdma_data    (wdma_data)
);

`default_nettype wire

/* sim/tb_dma_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dma_controller;
   import dma_pkg::*;

   localparam int oam_bytes      = 160;
   localparam int timeout_cycles = 2000;

   logic  I_CLK = 1'b0;
   logic  I_SYNC_RESET;
   addr_t ioreg_addr;
   byte_t ioreg_wdata;
   logic  ioreg_we_l;
   logic  ioreg_re_l;
   byte_t ioreg_rdata;
   addr_t rdma_addr;
   logic  rdma_re_l;
   byte_t rdma_data;
   addr_t wdma_addr;
   byte_t wdma_data;
   logic  wdma_we_l;
   logic  halt_cpu;

   logic  chk_en;      // outputs are known from here on
   logic  rd_chk;      // a register read is being checked
   logic  exp_en_l;
   logic  exp_halt;
   addr_t exp_rd_addr;
   addr_t exp_wr_addr;
   byte_t exp_rdata;
   string test_name;
   int    errors;
   int    cycles = 0;
   int    seed;
   byte_t page;
   byte_t h1;
   byte_t h2;
   byte_t h3;
   byte_t h4;

   dma_controller dma_controller_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .ioreg_addr   (ioreg_addr),
      .ioreg_wdata  (ioreg_wdata),
      .ioreg_we_l   (ioreg_we_l),
      .ioreg_re_l   (ioreg_re_l),
      .ioreg_rdata  (ioreg_rdata),
      .rdma_addr    (rdma_addr),
      .rdma_re_l    (rdma_re_l),
      .rdma_data    (rdma_data),
      .wdma_addr    (wdma_addr),
      .wdma_data    (wdma_data),
      .wdma_we_l    (wdma_we_l),
      .halt_cpu     (halt_cpu)
   );

   assign rdma_data = rdma_addr[7:0] ^ 8'h5A; // model memory contents

   always #5 I_CLK = ~I_CLK;

   always @(posedge I_CLK) begin
      cycles <= cycles + 1;
      if (cycles == timeout_cycles) begin
         $display("simulation timed out after %0d cycles", cycles);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic report_mismatch(input string what, input logic [15:0] expv,
                                  input logic [15:0] actv);
      errors++;
      $display("FAIL %s: %s expected %h actual %h", test_name, what, expv, actv);
   endtask

   chk_re: assert property (@(posedge I_CLK) chk_en |-> rdma_re_l == exp_en_l)
      else report_mismatch("rdma_re_l", $sampled(exp_en_l), $sampled(rdma_re_l));
   chk_we: assert property (@(posedge I_CLK) chk_en |-> wdma_we_l == exp_en_l)
      else report_mismatch("wdma_we_l", $sampled(exp_en_l), $sampled(wdma_we_l));
   chk_halt: assert property (@(posedge I_CLK) chk_en |-> halt_cpu == exp_halt)
      else report_mismatch("halt_cpu", $sampled(exp_halt), $sampled(halt_cpu));
   chk_rd_addr: assert property (@(posedge I_CLK) chk_en |-> rdma_addr == exp_rd_addr)
      else report_mismatch("rdma_addr", $sampled(exp_rd_addr), $sampled(rdma_addr));
   chk_wr_addr: assert property (@(posedge I_CLK) chk_en |-> wdma_addr == exp_wr_addr)
      else report_mismatch("wdma_addr", $sampled(exp_wr_addr), $sampled(wdma_addr));
   chk_wr_data: assert property (@(posedge I_CLK)
      chk_en |-> wdma_data == (exp_rd_addr[7:0] ^ 8'h5A))
      else report_mismatch("wdma_data", $sampled(exp_rd_addr[7:0] ^ 8'h5A),
                           $sampled(wdma_data));
   chk_rdata: assert property (@(posedge I_CLK) (chk_en && rd_chk) |-> ioreg_rdata == exp_rdata)
      else report_mismatch("ioreg_rdata", $sampled(exp_rdata), $sampled(ioreg_rdata));

   task automatic tick();
      @(posedge I_CLK);
      #1;
   endtask

   task automatic set_idle();
      exp_en_l    = 1'b1;
      exp_halt    = 1'b0;
      exp_rd_addr = 16'h0000;
      exp_wr_addr = 16'h0000;
   endtask

   function automatic addr_t reg_at(input int i);
      case (i)
         0:       return reg_dma_addr;
         1:       return reg_hdma1_addr;
         2:       return reg_hdma2_addr;
         3:       return reg_hdma3_addr;
         4:       return reg_hdma4_addr;
         default: return reg_hdma5_addr;
      endcase
   endfunction

   task automatic write_reg(input addr_t a, input byte_t d);
      ioreg_addr  = a;
      ioreg_wdata = d;
      ioreg_we_l  = 1'b0;
      tick();
      ioreg_we_l  = 1'b1;
   endtask

   task automatic read_reg(input addr_t a, input byte_t e);
      ioreg_addr = a;
      ioreg_re_l = 1'b0;
      exp_rdata  = e;
      rd_chk     = 1'b1;
      tick();
      ioreg_re_l = 1'b1;
      rd_chk     = 1'b0;
   endtask

   task automatic run_oam(input byte_t p);
      test_name = "oam_transfer";
      write_reg(reg_dma_addr, p);
      tick();                         // start pulse cycle
      for (int k = 0; k < oam_bytes; k++) begin
         exp_en_l    = 1'b0;
         exp_rd_addr = {p, 8'h00} + 16'(k);
         exp_wr_addr = 16'hFE00 + 16'(k);
         tick();
      end
      set_idle();
      read_reg(reg_dma_addr, p);
   endtask

   task automatic run_gdma(input int n);
      int    len;
      addr_t src;
      addr_t dst;
      test_name = "gdma_transfer";
      len = 16 * (n + 1);
      src = {h1, h2[7:4], 4'h0};
      dst = 16'h8000 + {3'b000, h3[4:0], h4[7:4], 4'h0};
      write_reg(reg_hdma5_addr, 8'(n));
      ioreg_addr = reg_hdma5_addr;    // watch the status all through
      ioreg_re_l = 1'b0;
      rd_chk     = 1'b1;
      exp_rdata  = 8'h00;
      tick();
      for (int k = 0; k < len; k++) begin
         exp_en_l    = 1'b0;
         exp_halt    = 1'b1;
         exp_rd_addr = src + 16'(k);
         exp_wr_addr = dst + 16'(k);
         exp_rdata   = 8'h80 | 8'((len - k + 15) / 16 - 1); // blocks not yet finished
         tick();
      end
      set_idle();
      exp_rdata = 8'h00;
      tick();
      tick();
      ioreg_re_l = 1'b1;
      rd_chk     = 1'b0;
   endtask

   initial begin
      I_SYNC_RESET = 1'b1;
      ioreg_addr   = 16'h0000;
      ioreg_wdata  = 8'h00;
      ioreg_we_l   = 1'b1;
      ioreg_re_l   = 1'b1;
      seed         = 35;
      errors       = 0;
      chk_en       = 1'b0;
      rd_chk       = 1'b0;
      exp_rdata    = 8'h00;
      test_name    = "reset";
      set_idle();
      tick();
      chk_en = 1'b1;
      for (int i = 0; i < 9; i++) read_reg(reg_at(i % 6), 8'h00);
      I_SYNC_RESET = 1'b0;            // held for 10 edges
      test_name = "after_reset";
      for (int i = 0; i < 6; i++) read_reg(reg_at(i), 8'h00);

      page = 8'($random(seed));
      run_oam(page);

      test_name = "reg_readback";
      h1 = 8'($random(seed));
      h2 = 8'($random(seed));
      h3 = 8'($random(seed));
      h4 = 8'($random(seed));
      write_reg(reg_hdma1_addr, h1);
      write_reg(reg_hdma2_addr, h2);
      write_reg(reg_hdma3_addr, h3);
      write_reg(reg_hdma4_addr, h4);
      read_reg(reg_hdma1_addr, h1);
      read_reg(reg_hdma2_addr, h2);
      read_reg(reg_hdma3_addr, h3);
      read_reg(reg_hdma4_addr, h4);
      read_reg(reg_hdma5_addr, 8'h00);

      run_gdma($random(seed) & 7);

      test_name = "hblank_ignored";
      write_reg(reg_hdma5_addr, 8'h80 | 8'($random(seed)));
      for (int i = 0; i < 40; i++) read_reg(reg_hdma5_addr, 8'h00);

      $display("errors: %0d", errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
design/dma_pkg.sv
design/dma_io_regs.sv
design/oam_dma_engine.sv
design/gdma_engine.sv
design/dma_bus_arbiter.sv
design/dma_controller.sv
sim/dma_controller_assertions.sv
sim/tb_dma_controller.sv
